/* source/eu_types_pkg.sv */
// Event unit data widths, payload types and core limits
package eu_types_pkg;

   // Bus and payload types
   typedef logic [31:0] word_t;    // One bus data word
   typedef logic [63:0] line_t;    // Mask or buffer of one core, {high, low}
   typedef logic [7:0]  irq_id_t;  // Encoded interrupt id

   // Largest core count the address map can hold
   localparam int MAX_CORES = 8;

   // Id returned when no interrupt is pending
   localparam irq_id_t IRQ_ID_NONE = 8'hFF;

   // Barrier trigger plus three general purpose lines
   localparam int NUM_INT_EVENTS = 4;

endpackage

/* source/eu_regmap_pkg.sv */
// Event unit address map with field positions, group codes and word offsets
package eu_regmap_pkg;

   // ****************************************
   // Address fields
   // ****************************************
   localparam int IRQ_BIT   = 9;
   localparam int EVENT_BIT = 8;
   localparam int OFF_HI    = 7;  // Word offset, upper bit
   localparam int OFF_LO    = 2;  // Word offset, lower bit

   // Group taken from {IRQ_BIT, EVENT_BIT}
   typedef enum logic [1:0]
   {
      GRP_NONE  = 2'b00,  // Former body-bias group, acknowledged only
      GRP_EVENT = 2'b01,
      GRP_IRQ   = 2'b10,
      GRP_CTRL  = 2'b11
   } eu_group_e;

   // ****************************************
   // Event and interrupt groups
   // ****************************************
   localparam logic [5:0] MASK_LOW_BASE  = 6'd0;   // Plus core index
   localparam logic [5:0] MASK_HIGH_BASE = 6'd8;
   localparam logic [5:0] BUF_LOW_BASE   = 6'd16;
   localparam logic [5:0] BUF_HIGH_BASE  = 6'd24;

   // ****************************************
   // Control group
   // ****************************************
   localparam logic [5:0] CORE_CLKGATE      = 6'd2;
   localparam logic [5:0] EMERG_EVENT_SET   = 6'd3;
   localparam logic [5:0] EMERG_IRQ_SET     = 6'd4;
   localparam logic [5:0] EMERG_IRQ_CLEAR   = 6'd5;
   localparam logic [5:0] EMERG_EVENT_CLEAR = 6'd6;
   localparam logic [5:0] INT_EVENT_BASE    = 6'd8;   // Barrier trigger, then GP 0 to 2
   localparam logic [5:0] IDLE_CNT_CLEAR    = 6'd12;
   localparam logic [5:0] IDLE_CNT_START    = 6'd13;
   localparam logic [5:0] IRQ_ID_BASE       = 6'd16;  // Plus core index, read only
   localparam logic [5:0] IDLE_CNT_BASE     = 6'd24;  // Plus core index, read only

endpackage

/* source/eu_bus_fsm.sv */
// Peripheral bus FSM with group decode and one-cycle registered read response
`timescale 1ns/100ps

module eu_bus_fsm
   import eu_types_pkg::*;
   import eu_regmap_pkg::*;
#(
   parameter int ID_W = 5
)
(
   input  logic            clk_i,
   input  logic            rst_ni,
   input  logic            req_i,
   input  word_t           add_i,
   input  logic            wen_i,        // 1 read, 0 write
   input  logic [ID_W-1:0] id_i,
   input  word_t           ev_rdata_i,
   input  word_t           irq_rdata_i,
   input  word_t           ctrl_rdata_i,
   output logic            gnt_o,
   output logic [5:0]      offset_o,
   output logic            ev_we_o,
   output logic            irq_we_o,
   output logic            ctrl_we_o,
   output logic            r_valid_o,
   output word_t           r_rdata_o,
   output logic [ID_W-1:0] r_id_o
);

   typedef enum logic {IDLE, RESP} state_e;

   state_e          state_q;
   state_e          state_d;
   eu_group_e       grp;
   logic            wr;
   word_t           rdata_d;
   word_t           rdata_q;
   logic [ID_W-1:0] id_q;

   assign gnt_o    = req_i;  // Always accepted
   assign grp      = eu_group_e'({add_i[IRQ_BIT], add_i[EVENT_BIT]});
   assign offset_o = add_i[OFF_HI:OFF_LO];
   assign wr       = req_i & ~wen_i;

   assign ev_we_o   = wr & (grp == GRP_EVENT);
   assign irq_we_o  = wr & (grp == GRP_IRQ);
   assign ctrl_we_o = wr & (grp == GRP_CTRL);

   // Read word to capture, zero on writes
   always_comb
   begin
      rdata_d = '0;
      if (req_i && wen_i)
      begin
         case (grp)
            GRP_EVENT: rdata_d = ev_rdata_i;
            GRP_IRQ:   rdata_d = irq_rdata_i;
            GRP_CTRL:  rdata_d = ctrl_rdata_i;
            default:   rdata_d = '0;  // Old body-bias group reads zero
         endcase
      end
   end

   // RESP holds as long as requests keep coming
   assign state_d = req_i ? RESP : IDLE;

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
         state_q <= IDLE;
      else
         state_q <= state_d;
   end

   always_ff @(posedge clk_i)
   begin
      if (req_i)
      begin
         id_q    <= id_i;
         rdata_q <= rdata_d;
      end
   end

   assign r_valid_o = (state_q == RESP);
   assign r_rdata_o = rdata_q;
   assign r_id_o    = id_q;

   a_resp_follows_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      r_valid_o == $past(req_i));

endmodule

/* source/eu_line_access.sv */
// Per-core mask write, buffer clear and readback for one line kind
`timescale 1ns/100ps

module eu_line_access
   import eu_types_pkg::*;
   import eu_regmap_pkg::*;
#(
   parameter int NUM_CORES = 4
)
(
   input  logic [5:0]                 offset_i,
   input  logic                       we_i,
   input  word_t                      wdata_i,
   input  line_t [NUM_CORES-1:0]      mask_reg_i,    // External mask registers
   input  line_t [NUM_CORES-1:0]      buf_status_i,
   output line_t [NUM_CORES-1:0]      mask_o,
   output logic  [NUM_CORES-1:0][1:0] mask_sel_o,    // {high, low} per core
   output line_t [NUM_CORES-1:0]      buf_clear_o,
   output word_t                      rdata_o
);

   always_comb
   begin
      mask_o      = '0;
      mask_sel_o  = '0;
      buf_clear_o = '0;
      rdata_o     = '0;

      for (int i = 0; i < NUM_CORES; i++)
      begin
         if (offset_i == MASK_LOW_BASE + 6'(i))
         begin
            if (we_i)
            begin
               mask_o[i][31:0]  = wdata_i;
               mask_sel_o[i][0] = 1'b1;
            end
            rdata_o = mask_reg_i[i][31:0];
         end
         else if (offset_i == MASK_HIGH_BASE + 6'(i))
         begin
            if (we_i)
            begin
               mask_o[i][63:32] = wdata_i;
               mask_sel_o[i][1] = 1'b1;
            end
            rdata_o = mask_reg_i[i][63:32];
         end
         // Buffer writes clear the bits set in wdata
         else if (offset_i == BUF_LOW_BASE + 6'(i))
         begin
            if (we_i)
               buf_clear_o[i][31:0] = wdata_i;
            rdata_o = buf_status_i[i][31:0];
         end
         else if (offset_i == BUF_HIGH_BASE + 6'(i))
         begin
            if (we_i)
               buf_clear_o[i][63:32] = wdata_i;
            rdata_o = buf_status_i[i][63:32];
         end
      end
   end

   // Mask registers only load on an accepted write
   always_comb
   begin
      a_sel_needs_we: assert (we_i || mask_sel_o == '0)
         else $error("mask_sel_o raised without a write");
   end

endmodule

/* source/eu_core_ctrl.sv */
// Control group with clock stop, sleep status, emergency and internal event strobes
`timescale 1ns/100ps

module eu_core_ctrl
   import eu_types_pkg::*;
   import eu_regmap_pkg::*;
#(
   parameter int NUM_CORES = 4
)
(
   input  logic                                     clk_i,
   input  logic                                     rst_ni,
   input  logic [5:0]                               offset_i,
   input  logic                                     we_i,
   input  word_t                                    wdata_i,
   input  logic [NUM_CORES-1:0]                     event_detect_i,
   input  logic [NUM_CORES-1:0]                     emerg_event_status_i,
   input  logic [NUM_CORES-1:0]                     emerg_irq_status_i,
   input  irq_id_t [NUM_CORES-1:0]                  irq_id_i,
   input  word_t [NUM_CORES-1:0]                    idle_cnt_i,
   output logic [NUM_CORES-1:0]                     clk_stop_o,
   output logic [NUM_CORES-1:0]                     core_sleep_o,
   output logic [NUM_CORES-1:0]                     emerg_event_o,
   output logic [NUM_CORES-1:0]                     emerg_irq_o,
   output logic [NUM_CORES-1:0]                     emerg_event_clear_o,
   output logic [NUM_CORES-1:0]                     emerg_irq_clear_o,
   output logic [NUM_INT_EVENTS-1:0][NUM_CORES-1:0] int_event_o,
   output logic [NUM_CORES-1:0]                     cnt_clear_o,
   output logic                                     cnt_start_we_o,
   output logic [NUM_CORES-1:0]                     cnt_start_o,
   output word_t                                    rdata_o
);

   localparam int CORE_W = $clog2(MAX_CORES);

   logic [CORE_W-1:0]    core_sel;  // Core index carried in wdata
   logic [NUM_CORES-1:0] sleep_q;

   assign core_sel = wdata_i[CORE_W-1:0];

   // ****************************************
   // Write decode
   // ****************************************
   always_comb
   begin
      clk_stop_o          = '0;
      emerg_event_o       = '0;
      emerg_irq_o         = '0;
      emerg_event_clear_o = '0;
      emerg_irq_clear_o   = '0;
      int_event_o         = '0;
      cnt_clear_o         = '0;
      cnt_start_we_o      = 1'b0;
      cnt_start_o         = '0;

      if (we_i)
      begin
         case (offset_i)
            CORE_CLKGATE:
               for (int i = 0; i < NUM_CORES; i++)
                  clk_stop_o[i] = (core_sel == CORE_W'(i));
            EMERG_EVENT_SET:   emerg_event_o       = wdata_i[NUM_CORES-1:0];
            EMERG_IRQ_SET:     emerg_irq_o         = wdata_i[NUM_CORES-1:0];
            EMERG_IRQ_CLEAR:   emerg_irq_clear_o   = wdata_i[NUM_CORES-1:0];
            EMERG_EVENT_CLEAR: emerg_event_clear_o = wdata_i[NUM_CORES-1:0];
            IDLE_CNT_CLEAR:
               for (int i = 0; i < NUM_CORES; i++)
                  cnt_clear_o[i] = (core_sel == CORE_W'(i));
            IDLE_CNT_START:
            begin
               cnt_start_we_o = 1'b1;
               cnt_start_o    = wdata_i[NUM_CORES-1:0];  // Enable mask
            end
            default:
               for (int e = 0; e < NUM_INT_EVENTS; e++)
                  if (offset_i == INT_EVENT_BASE + 6'(e))
                     int_event_o[e] = wdata_i[NUM_CORES-1:0];
         endcase
      end
   end

   // Sleep status, event detect wins over a new stop
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
         sleep_q <= '0;
      else
         sleep_q <= (sleep_q | clk_stop_o) & ~event_detect_i;
   end

   assign core_sleep_o = sleep_q;

   // ****************************************
   // Read word
   // ****************************************
   always_comb
   begin
      rdata_o = '0;
      case (offset_i)
         CORE_CLKGATE:    rdata_o[NUM_CORES-1:0] = sleep_q;
         EMERG_EVENT_SET: rdata_o[NUM_CORES-1:0] = emerg_event_status_i;
         EMERG_IRQ_SET:   rdata_o[NUM_CORES-1:0] = emerg_irq_status_i;
         default:
            for (int i = 0; i < NUM_CORES; i++)
            begin
               if (offset_i == IRQ_ID_BASE + 6'(i))
                  rdata_o[7:0] = irq_id_i[i];
               else if (offset_i == IDLE_CNT_BASE + 6'(i))
                  rdata_o = idle_cnt_i[i];
            end
      endcase
   end

   a_clk_stop_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(clk_stop_o));

endmodule

/* source/eu_idle_counter.sv */
// Per-core saturating idle-cycle counters with enable mask and clear
`timescale 1ns/100ps

module eu_idle_counter
   import eu_types_pkg::*;
#(
   parameter int NUM_CORES = 4
)
(
   input  logic                  clk_i,
   input  logic                  rst_ni,
   input  logic [NUM_CORES-1:0]  sleep_i,
   input  logic [NUM_CORES-1:0]  clear_i,     // One-hot clear strobe
   input  logic                  start_we_i,
   input  logic [NUM_CORES-1:0]  start_i,
   output word_t [NUM_CORES-1:0] count_o
);

   logic [NUM_CORES-1:0]  enable_q;
   word_t [NUM_CORES-1:0] count_q;

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         enable_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (start_we_i)
            enable_q <= start_i;
         for (int i = 0; i < NUM_CORES; i++)
         begin
            if (clear_i[i])
               count_q[i] <= '0;
            else if (enable_q[i] && sleep_i[i] && count_q[i] != '1)
               count_q[i] <= count_q[i] + 32'd1;  // Stops at all ones
         end
      end
   end

   assign count_o = count_q;

   for (genvar g = 0; g < NUM_CORES; g++)
   begin : g_mono_chk
      a_count_monotonic: assert property (@(posedge clk_i) disable iff (!rst_ni)
         !clear_i[g] |=> count_q[g] >= $past(count_q[g]));
   end

endmodule

/* source/eu_irq_id_arbiter.sv */
// Fixed-priority encoder giving the lowest pending interrupt of one core
`timescale 1ns/100ps

module eu_irq_id_arbiter
   import eu_types_pkg::*;
(
   input  line_t   status_i,
   output irq_id_t id_o
);

   // Scan downwards so bit 0 has the highest priority
   always_comb
   begin
      id_o = IRQ_ID_NONE;
      for (int b = $bits(line_t) - 1; b >= 0; b--)
      begin
         if (status_i[b])
            id_o = irq_id_t'(b);
      end
   end

endmodule

/* source/event_unit_regs.sv */
// Event unit register front end between the peripheral bus and the per-core lines
`timescale 1ns/100ps

module event_unit_regs
   import eu_types_pkg::*;
#(
   parameter int NUM_CORES = 4,
   parameter int ID_W      = 5
)
(
   input  logic                                     clk_i,
   input  logic                                     rst_ni,
   // Peripheral bus
   input  logic                                     req_i,
   input  word_t                                    add_i,
   input  logic                                     wen_i,
   input  word_t                                    wdata_i,
   input  logic [ID_W-1:0]                          id_i,
   output logic                                     gnt_o,
   output logic                                     r_valid_o,
   output word_t                                    r_rdata_o,
   output logic [ID_W-1:0]                          r_id_o,
   // Event lines
   input  line_t [NUM_CORES-1:0]                    ev_mask_reg_i,
   input  line_t [NUM_CORES-1:0]                    ev_buf_status_i,
   output line_t [NUM_CORES-1:0]                    ev_mask_o,
   output logic [NUM_CORES-1:0][1:0]                ev_mask_sel_o,
   output line_t [NUM_CORES-1:0]                    ev_buf_clear_o,
   // Interrupt lines
   input  line_t [NUM_CORES-1:0]                    irq_mask_reg_i,
   input  line_t [NUM_CORES-1:0]                    irq_buf_status_i,
   output line_t [NUM_CORES-1:0]                    irq_mask_o,
   output logic [NUM_CORES-1:0][1:0]                irq_mask_sel_o,
   output line_t [NUM_CORES-1:0]                    irq_buf_clear_o,
   // Core control
   input  logic [NUM_CORES-1:0]                     event_detect_i,
   input  logic [NUM_CORES-1:0]                     emerg_event_status_i,
   input  logic [NUM_CORES-1:0]                     emerg_irq_status_i,
   output logic [NUM_CORES-1:0]                     clk_stop_o,
   output logic [NUM_CORES-1:0]                     core_sleep_o,
   output logic [NUM_CORES-1:0]                     emerg_event_o,
   output logic [NUM_CORES-1:0]                     emerg_irq_o,
   output logic [NUM_CORES-1:0]                     emerg_event_clear_o,
   output logic [NUM_CORES-1:0]                     emerg_irq_clear_o,
   output logic [NUM_INT_EVENTS-1:0][NUM_CORES-1:0] int_event_o
);

   logic [5:0]              offset;
   logic                    ev_we;
   logic                    irq_we;
   logic                    ctrl_we;
   word_t                   ev_rdata;
   word_t                   irq_rdata;
   word_t                   ctrl_rdata;
   irq_id_t [NUM_CORES-1:0] irq_id;
   logic [NUM_CORES-1:0]    cnt_clear;
   logic                    cnt_start_we;
   logic [NUM_CORES-1:0]    cnt_start;
   word_t [NUM_CORES-1:0]   idle_cnt;

   eu_bus_fsm #(.ID_W(ID_W)) u_fsm
   (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .req_i        (req_i),
      .add_i        (add_i),
      .wen_i        (wen_i),
      .id_i         (id_i),
      .ev_rdata_i   (ev_rdata),
      .irq_rdata_i  (irq_rdata),
      .ctrl_rdata_i (ctrl_rdata),
      .gnt_o        (gnt_o),
      .offset_o     (offset),
      .ev_we_o      (ev_we),
      .irq_we_o     (irq_we),
      .ctrl_we_o    (ctrl_we),
      .r_valid_o    (r_valid_o),
      .r_rdata_o    (r_rdata_o),
      .r_id_o       (r_id_o)
   );

   // ****************************************
   // Event and interrupt line access
   // ****************************************
   eu_line_access #(.NUM_CORES(NUM_CORES)) u_ev
   (
      .offset_i     (offset),
      .we_i         (ev_we),
      .wdata_i      (wdata_i),
      .mask_reg_i   (ev_mask_reg_i),
      .buf_status_i (ev_buf_status_i),
      .mask_o       (ev_mask_o),
      .mask_sel_o   (ev_mask_sel_o),
      .buf_clear_o  (ev_buf_clear_o),
      .rdata_o      (ev_rdata)
   );

   eu_line_access #(.NUM_CORES(NUM_CORES)) u_irq
   (
      .offset_i     (offset),
      .we_i         (irq_we),
      .wdata_i      (wdata_i),
      .mask_reg_i   (irq_mask_reg_i),
      .buf_status_i (irq_buf_status_i),
      .mask_o       (irq_mask_o),
      .mask_sel_o   (irq_mask_sel_o),
      .buf_clear_o  (irq_buf_clear_o),
      .rdata_o      (irq_rdata)
   );

   // One id encoder per core, fed by the interrupt buffers
   for (genvar i = 0; i < NUM_CORES; i++)
   begin : g_irq_id
      eu_irq_id_arbiter u_arb
      (
         .status_i (irq_buf_status_i[i]),
         .id_o     (irq_id[i])
      );
   end

   eu_core_ctrl #(.NUM_CORES(NUM_CORES)) u_ctrl
   (
      .clk_i                (clk_i),
      .rst_ni               (rst_ni),
      .offset_i             (offset),
      .we_i                 (ctrl_we),
      .wdata_i              (wdata_i),
      .event_detect_i       (event_detect_i),
      .emerg_event_status_i (emerg_event_status_i),
      .emerg_irq_status_i   (emerg_irq_status_i),
      .irq_id_i             (irq_id),
      .idle_cnt_i           (idle_cnt),
      .clk_stop_o           (clk_stop_o),
      .core_sleep_o         (core_sleep_o),
      .emerg_event_o        (emerg_event_o),
      .emerg_irq_o          (emerg_irq_o),
      .emerg_event_clear_o  (emerg_event_clear_o),
      .emerg_irq_clear_o    (emerg_irq_clear_o),
      .int_event_o          (int_event_o),
      .cnt_clear_o          (cnt_clear),
      .cnt_start_we_o       (cnt_start_we),
      .cnt_start_o          (cnt_start),
      .rdata_o              (ctrl_rdata)
   );

   eu_idle_counter #(.NUM_CORES(NUM_CORES)) u_idle
   (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .sleep_i    (core_sleep_o),  // Counts while the core is stopped
      .clear_i    (cnt_clear),
      .start_we_i (cnt_start_we),
      .start_i    (cnt_start),
      .count_o    (idle_cnt)
   );

endmodule

/* tests/tb_event_unit_regs.sv */
// Testbench for the event unit register front end with assertion based checks
`timescale 1ns/100ps

module tb_event_unit_regs;
   import eu_types_pkg::*;
   import eu_regmap_pkg::*;

   localparam int NC          = 4;
   localparam int TEST_CYCLES = 200;  // Rough length of all tests

   logic clk = 1'b0;
   logic rst_n;
   logic req_i, wen_i, gnt_o, r_valid_o;
   word_t add_i, wdata_i, r_rdata_o;
   logic [4:0] id_i, r_id_o;
   line_t [NC-1:0] ev_mask_reg, ev_buf_status, ev_mask_o, ev_buf_clear_o;
   line_t [NC-1:0] irq_mask_reg, irq_buf_status, irq_mask_o, irq_buf_clear_o;
   logic [NC-1:0][1:0] ev_mask_sel_o, irq_mask_sel_o;
   logic [NC-1:0] event_detect, emerg_ev_status, emerg_irq_status;
   logic [NC-1:0] clk_stop_o, core_sleep_o, emerg_event_o, emerg_irq_o;
   logic [NC-1:0] emerg_event_clear_o, emerg_irq_clear_o;
   logic [NUM_INT_EVENTS-1:0][NC-1:0] int_event_o;

   // Expected values driven together with each request
   line_t [NC-1:0] exp_ev_mask, exp_irq_mask, exp_ev_clr, exp_irq_clr;
   logic [NC-1:0][1:0] exp_ev_sel, exp_irq_sel;
   logic [NC-1:0] exp_clk_stop, exp_em_ev, exp_em_irq, exp_em_ev_clr, exp_em_irq_clr;
   logic [NUM_INT_EVENTS-1:0][NC-1:0] exp_int_ev;
   word_t exp_rdata, rdata_prev;
   logic chk_ge, ge_q, ge_qq;
   int seed = 32'h01ca_2e22;
   int errors = 0;
   int tests_run = 0;
   logic [4:0] next_id = '0;
   logic [NC-1:0] sleep_exp;

   always #5 clk = ~clk;

   event_unit_regs #(.NUM_CORES(NC), .ID_W(5)) dut0
   (
      .clk_i(clk), .rst_ni(rst_n), .req_i(req_i), .add_i(add_i), .wen_i(wen_i),
      .wdata_i(wdata_i), .id_i(id_i), .gnt_o(gnt_o), .r_valid_o(r_valid_o),
      .r_rdata_o(r_rdata_o), .r_id_o(r_id_o),
      .ev_mask_reg_i(ev_mask_reg), .ev_buf_status_i(ev_buf_status), .ev_mask_o(ev_mask_o),
      .ev_mask_sel_o(ev_mask_sel_o), .ev_buf_clear_o(ev_buf_clear_o),
      .irq_mask_reg_i(irq_mask_reg), .irq_buf_status_i(irq_buf_status),
      .irq_mask_o(irq_mask_o), .irq_mask_sel_o(irq_mask_sel_o),
      .irq_buf_clear_o(irq_buf_clear_o),
      .event_detect_i(event_detect), .emerg_event_status_i(emerg_ev_status),
      .emerg_irq_status_i(emerg_irq_status), .clk_stop_o(clk_stop_o),
      .core_sleep_o(core_sleep_o), .emerg_event_o(emerg_event_o), .emerg_irq_o(emerg_irq_o),
      .emerg_event_clear_o(emerg_event_clear_o), .emerg_irq_clear_o(emerg_irq_clear_o),
      .int_event_o(int_event_o)
   );

   // External mask registers loaded per half
   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         ev_mask_reg  <= '0;
         irq_mask_reg <= '0;
      end
      else
         for (int i = 0; i < NC; i++)
         begin
            if (ev_mask_sel_o[i][0])  ev_mask_reg[i][31:0]   <= ev_mask_o[i][31:0];
            if (ev_mask_sel_o[i][1])  ev_mask_reg[i][63:32]  <= ev_mask_o[i][63:32];
            if (irq_mask_sel_o[i][0]) irq_mask_reg[i][31:0]  <= irq_mask_o[i][31:0];
            if (irq_mask_sel_o[i][1]) irq_mask_reg[i][63:32] <= irq_mask_o[i][63:32];
         end
   end

   // History for the idle count reads
   always_ff @(posedge clk)
   begin
      ge_q       <= req_i & chk_ge;
      ge_qq      <= ge_q;
      rdata_prev <= r_rdata_o;
   end

   task automatic show_mismatch(input string name, input logic [255:0] exp,
                                input logic [255:0] act);
      $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, exp, act);
      errors++;
   endtask

   task automatic show_problem(input string what);
      $display("[FAIL] t=%0t %s", $time, what);
      errors++;
   endtask

   // ****************************************
   // Checks
   // ****************************************
   a_gnt: assert property (@(posedge clk) disable iff (!rst_n) gnt_o == req_i)
      else show_mismatch("gnt_o", req_i, gnt_o);
   a_valid: assert property (@(posedge clk) disable iff (!rst_n) req_i |=> r_valid_o)
      else show_problem("no response one cycle after a request");
   a_idle: assert property (@(posedge clk) disable iff (!rst_n) !req_i |=> !r_valid_o)
      else show_problem("response without a request");
   a_id: assert property (@(posedge clk) disable iff (!rst_n) req_i |=> r_id_o == $past(id_i))
      else show_mismatch("r_id_o", $past(id_i), $sampled(r_id_o));
   a_data: assert property (@(posedge clk) disable iff (!rst_n)
      req_i && !chk_ge |=> r_rdata_o == $past(exp_rdata))
      else show_mismatch("r_rdata_o", $past(exp_rdata), $sampled(r_rdata_o));
   // Reads one cycle apart see one more idle cycle
   a_count: assert property (@(posedge clk) disable iff (!rst_n)
      ge_q && ge_qq |-> r_rdata_o == rdata_prev + 32'd1)
      else show_mismatch("r_rdata_o", $sampled(rdata_prev) + 32'd1, $sampled(r_rdata_o));
   a_ev_sel: assert property (@(posedge clk) disable iff (!rst_n)
      ev_mask_sel_o == exp_ev_sel)
      else show_mismatch("ev_mask_sel_o", exp_ev_sel, ev_mask_sel_o);
   a_ev_mask: assert property (@(posedge clk) disable iff (!rst_n)
      ev_mask_o == exp_ev_mask)
      else show_mismatch("ev_mask_o", exp_ev_mask, ev_mask_o);
   a_irq_sel: assert property (@(posedge clk) disable iff (!rst_n)
      irq_mask_sel_o == exp_irq_sel)
      else show_mismatch("irq_mask_sel_o", exp_irq_sel, irq_mask_sel_o);
   a_irq_mask: assert property (@(posedge clk) disable iff (!rst_n)
      irq_mask_o == exp_irq_mask)
      else show_mismatch("irq_mask_o", exp_irq_mask, irq_mask_o);
   a_ev_clr: assert property (@(posedge clk) disable iff (!rst_n) ev_buf_clear_o == exp_ev_clr)
      else show_mismatch("ev_buf_clear_o", exp_ev_clr, ev_buf_clear_o);
   a_irq_clr: assert property (@(posedge clk) disable iff (!rst_n) irq_buf_clear_o == exp_irq_clr)
      else show_mismatch("irq_buf_clear_o", exp_irq_clr, irq_buf_clear_o);
   a_stop: assert property (@(posedge clk) disable iff (!rst_n) clk_stop_o == exp_clk_stop)
      else show_mismatch("clk_stop_o", exp_clk_stop, clk_stop_o);
   a_emerg: assert property (@(posedge clk) disable iff (!rst_n)
      {emerg_event_o, emerg_irq_o, emerg_event_clear_o, emerg_irq_clear_o}
      == {exp_em_ev, exp_em_irq, exp_em_ev_clr, exp_em_irq_clr})
      else show_mismatch("emerg strobes", {exp_em_ev, exp_em_irq, exp_em_ev_clr,
         exp_em_irq_clr}, {emerg_event_o, emerg_irq_o, emerg_event_clear_o, emerg_irq_clear_o});
   a_int_ev: assert property (@(posedge clk) disable iff (!rst_n) int_event_o == exp_int_ev)
      else show_mismatch("int_event_o", exp_int_ev, int_event_o);
   a_wake: assert property (@(posedge clk) disable iff (!rst_n)
      |event_detect |=> (core_sleep_o & $past(event_detect)) == '0)
      else show_problem("event detect did not clear the sleep bit");

   // Lowest pending interrupt scanned from bit 0 up
   function automatic word_t lowest_set(input line_t v);
      word_t id;
      logic found;
      id = 32'hFF;
      found = 1'b0;
      for (int b = 0; b < 64; b++)
         if (v[b] && !found)
         begin
            id = b;
            found = 1'b1;
         end
      return id;
   endfunction

   task automatic clear_exp();
      exp_ev_mask    = '0;
      exp_irq_mask   = '0;
      exp_ev_clr     = '0;
      exp_irq_clr    = '0;
      exp_ev_sel     = '0;
      exp_irq_sel    = '0;
      exp_clk_stop   = '0;
      exp_int_ev     = '0;
      exp_em_ev      = '0;
      exp_em_irq     = '0;
      exp_em_ev_clr  = '0;
      exp_em_irq_clr = '0;
      exp_rdata      = '0;
      chk_ge         = 1'b0;
   endtask

   // One bus access with group {irq, event} and word offset
   task automatic bus_access(input logic rd, input logic [1:0] grp, input logic [5:0] off,
                             input word_t data, input word_t exp);
      req_i     = 1'b1;
      wen_i     = rd;
      add_i     = {22'd0, grp, off, 2'b00};
      wdata_i   = data;
      id_i      = next_id;
      next_id   = next_id + 5'd1;
      exp_rdata = rd ? exp : '0;
      @(posedge clk);
      #1;
      req_i = 1'b0;
      clear_exp();
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      $display("test %s finished, errors so far %0d", name, errors);
   endtask

   initial
   begin
      word_t w;
      line_t st;
      logic [5:0] off;
      rst_n            = 1'b0;
      req_i            = 1'b0;
      wen_i            = 1'b0;
      add_i            = '0;
      wdata_i          = '0;
      id_i             = '0;
      ev_buf_status    = '0;
      irq_buf_status   = '0;
      event_detect     = '0;
      emerg_ev_status  = '0;
      emerg_irq_status = '0;
      sleep_exp        = '0;
      clear_exp();
      repeat (2) @(posedge clk);
      #1 rst_n = 1'b1;
      @(posedge clk);
      #1;

      // Old body-bias group back to back
      bus_access(1'b0, 2'b00, 6'd1, $random(seed), '0);
      bus_access(1'b1, 2'b00, 6'd1, '0, '0);
      bus_access(1'b1, 2'b00, 6'd7, '0, '0);
      finish_test("bus response");

      for (int k = 0; k < 2; k++)        // Events first and interrupts second
         for (int c = 0; c < NC; c++)
            for (int h = 0; h < 2; h++)
            begin
               w   = $random(seed);
               off = (h ? MASK_HIGH_BASE : MASK_LOW_BASE) + 6'(c);
               if (k == 0)
               begin
                  exp_ev_sel[c][h] = 1'b1;
                  exp_ev_mask[c][h*32 +: 32] = w;
               end
               else
               begin
                  exp_irq_sel[c][h] = 1'b1;
                  exp_irq_mask[c][h*32 +: 32] = w;
               end
               bus_access(1'b0, k ? 2'b10 : 2'b01, off, w, '0);
               bus_access(1'b1, k ? 2'b10 : 2'b01, off, '0, w);
            end
      finish_test("masks");

      for (int c = 0; c < NC; c++)
      begin
         ev_buf_status[c]  = {$random(seed), $random(seed)};
         irq_buf_status[c] = {$random(seed), $random(seed)};
      end
      for (int k = 0; k < 2; k++)
         for (int c = 0; c < NC; c++)
            for (int h = 0; h < 2; h++)
            begin
               w   = $random(seed);
               off = (h ? BUF_HIGH_BASE : BUF_LOW_BASE) + 6'(c);
               if (k == 0)
                  exp_ev_clr[c][h*32 +: 32] = w;
               else
                  exp_irq_clr[c][h*32 +: 32] = w;
               bus_access(1'b0, k ? 2'b10 : 2'b01, off, w, '0);
               st = k ? irq_buf_status[c] : ev_buf_status[c];
               bus_access(1'b1, k ? 2'b10 : 2'b01, off, '0, st[h*32 +: 32]);
            end
      finish_test("buffers");

      irq_buf_status[0] = '0;
      irq_buf_status[1] = 64'h8000_0000_0000_0000;
      irq_buf_status[2] = {$random(seed), $random(seed)} << 5;
      irq_buf_status[3] = 64'h0000_0001_0000_0000;
      for (int c = 0; c < NC; c++)
         bus_access(1'b1, 2'b11, IRQ_ID_BASE + 6'(c), '0, lowest_set(irq_buf_status[c]));
      finish_test("irq id");

      for (int c = 0; c < NC; c++)
      begin
         exp_clk_stop[c] = 1'b1;
         sleep_exp[c]    = 1'b1;
         bus_access(1'b0, 2'b11, CORE_CLKGATE, c, '0);
         bus_access(1'b1, 2'b11, CORE_CLKGATE, '0, sleep_exp);
      end
      event_detect[2] = 1'b1;
      sleep_exp[2]    = 1'b0;
      @(posedge clk);
      #1 event_detect = '0;
      bus_access(1'b1, 2'b11, CORE_CLKGATE, '0, sleep_exp);
      finish_test("clock stop");

      // Core 1 still sleeps and its count keeps rising
      bus_access(1'b0, 2'b11, IDLE_CNT_START, 32'h2, '0);
      for (int n = 0; n < 6; n++)
      begin
         chk_ge = 1'b1;
         bus_access(1'b1, 2'b11, IDLE_CNT_BASE + 6'd1, '0, '0);
      end
      bus_access(1'b0, 2'b11, IDLE_CNT_START, 32'h0, '0);
      bus_access(1'b0, 2'b11, IDLE_CNT_CLEAR, 32'h1, '0);
      bus_access(1'b1, 2'b11, IDLE_CNT_BASE + 6'd1, '0, '0);
      emerg_ev_status = 4'(($random(seed)));
      bus_access(1'b1, 2'b11, EMERG_EVENT_SET, '0, emerg_ev_status);
      emerg_irq_status = 4'(($random(seed)));
      bus_access(1'b1, 2'b11, EMERG_IRQ_SET, '0, emerg_irq_status);
      w         = $random(seed);
      exp_em_ev = w[NC-1:0];
      bus_access(1'b0, 2'b11, EMERG_EVENT_SET, w, '0);
      w          = $random(seed);
      exp_em_irq = w[NC-1:0];
      bus_access(1'b0, 2'b11, EMERG_IRQ_SET, w, '0);
      w              = $random(seed);
      exp_em_irq_clr = w[NC-1:0];
      bus_access(1'b0, 2'b11, EMERG_IRQ_CLEAR, w, '0);
      w             = $random(seed);
      exp_em_ev_clr = w[NC-1:0];
      bus_access(1'b0, 2'b11, EMERG_EVENT_CLEAR, w, '0);
      for (int e = 0; e < NUM_INT_EVENTS; e++)
      begin
         w = $random(seed);
         exp_int_ev[e] = w[NC-1:0];
         bus_access(1'b0, 2'b11, INT_EVENT_BASE + 6'(e), w, '0);
      end
      finish_test("idle counter and strobes");

      repeat (2) @(posedge clk);
      $display("%0d tests run, %0d errors", tests_run, errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

   // Watchdog
   initial
   begin
      #(TEST_CYCLES * 10 + 500);
      $display("watchdog timeout, the run did not finish in time");
      $display("TESTS FAILED");
      $finish;
   end

endmodule

/* event_unit_regs.f */
source/eu_types_pkg.sv
source/eu_regmap_pkg.sv
source/eu_bus_fsm.sv
source/eu_line_access.sv
source/eu_core_ctrl.sv
source/eu_idle_counter.sv
source/eu_irq_id_arbiter.sv
source/event_unit_regs.sv
tests/tb_event_unit_regs.sv

/* Makefile */
# Verilator build and run for the event unit register front end

VERILATOR ?= verilator
TOP       ?= tb_event_unit_regs
FILELIST  ?= event_unit_regs.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
